// ==== design/emb_pkg.sv ====
package emb_pkg;

  // ----------------------------------------------------------------------
  // batch and vocabulary shape
  localparam int N        = 4;
  localparam int CHAR_LEN = 5;
  localparam int CHAR_NUM = 32;
  localparam int EMB_DIM  = 8;

  // element widths, gradient and weight
  localparam int DATA_N  = 4;
  localparam int N_LEN   = 16;
  localparam int N_LEN_W = 16;

  // ----------------------------------------------------------------------
  // table layout
  localparam int ROW_WORDS   = EMB_DIM / DATA_N;
  localparam int BATCH_WORDS = N * ROW_WORDS;
  localparam int TABLE_DEPTH = CHAR_NUM * ROW_WORDS;
  localparam int ADDR_WIDTH  = $clog2(TABLE_DEPTH);
  localparam int WORD_WIDTH  = DATA_N * N_LEN_W;
  localparam int GRAD_WIDTH  = DATA_N * N_LEN;

  // run to valid, two cycles of read/add latency past the last read
  localparam int BATCH_WAIT = BATCH_WORDS + 2;

  // engine counter widths
  localparam int TOK_CNT_W  = $clog2(N);
  localparam int ROW_CNT_W  = $clog2(ROW_WORDS);
  localparam int SEL_W      = $clog2(BATCH_WORDS);
  localparam int WORD_CNT_W = SEL_W + 1;

endpackage

// ==== design/emb_table.sv ====
`timescale 1ns/10ps

module emb_table import emb_pkg::*; (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [WORD_WIDTH-1:0] rdata,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [WORD_WIDTH-1:0] wdata,
  input  logic                  we
);

  // ----------------------------------------------------------------------
  // weight storage, contents undefined until the host loads it
  logic [WORD_WIDTH-1:0] mem [TABLE_DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== design/emb_backward.sv ====
`timescale 1ns/10ps

module emb_backward import emb_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       run,
  input  logic [N*CHAR_LEN-1:0]      d_forward,
  input  logic [N*EMB_DIM*N_LEN-1:0] d_backward,
  input  logic [WORD_WIDTH-1:0]      tab_rdata,
  output logic                       valid,
  output logic [ADDR_WIDTH-1:0]      eng_raddr,
  output logic [ADDR_WIDTH-1:0]      eng_waddr,
  output logic [WORD_WIDTH-1:0]      eng_wdata,
  output logic                       eng_we
);

  // ----------------------------------------------------------------------
  // unpacked views of the batch
  logic [CHAR_LEN-1:0]   tok  [N];
  logic [GRAD_WIDTH-1:0] grad [BATCH_WORDS];

  // read address walk
  logic [TOK_CNT_W-1:0]  tok_cnt;
  logic [ROW_CNT_W-1:0]  row_cnt;
  logic                  last_word;
  logic [ADDR_WIDTH-1:0] raddr_d1;

  // batch word tracking
  logic [WORD_CNT_W-1:0] word_cnt;
  logic [WORD_CNT_W-1:0] word_d1;
  logic [WORD_CNT_W-1:0] word_d2;
  logic [WORD_CNT_W-1:0] word_d3;
  logic                  rd_fire;
  logic                  fire_d1;

  for (genvar k = 0; k < N; k++) begin : g_tok
    assign tok[k] = d_forward[k*CHAR_LEN +: CHAR_LEN];
  end

  for (genvar j = 0; j < BATCH_WORDS; j++) begin : g_grad
    assign grad[j] = d_backward[j*GRAD_WIDTH +: GRAD_WIDTH];
  end

  // row base is token index times words per row
  assign eng_raddr = ADDR_WIDTH'(tok[tok_cnt]) * ADDR_WIDTH'(ROW_WORDS)
                   + ADDR_WIDTH'(row_cnt);

  assign last_word = (tok_cnt == TOK_CNT_W'(N - 1))
                  && (row_cnt == ROW_CNT_W'(ROW_WORDS - 1));

  assign rd_fire = run && (word_cnt < WORD_CNT_W'(BATCH_WORDS));

  // drops with run, no register in between
  assign valid = run && (word_d3 == WORD_CNT_W'(BATCH_WORDS));

  // ----------------------------------------------------------------------
  // row word / token counters, parked on word 0 while idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tok_cnt <= '0;
      row_cnt <= '0;
    end else if (!run) begin
      tok_cnt <= '0;
      row_cnt <= '0;
    end else if (!last_word) begin
      if (row_cnt == ROW_CNT_W'(ROW_WORDS - 1)) begin
        row_cnt <= '0;
        tok_cnt <= tok_cnt + 1'b1;
      end else begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // write address trails the read address by two cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      raddr_d1  <= '0;
      eng_waddr <= '0;
    end else begin
      raddr_d1  <= eng_raddr;
      eng_waddr <= raddr_d1;
    end
  end

  // ----------------------------------------------------------------------
  // batch word counter and delayed copies
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      word_d1  <= '0;
      word_d2  <= '0;
      word_d3  <= '0;
    end else if (!run) begin
      // flushed so a back-to-back batch cannot see a stale count
      word_cnt <= '0;
      word_d1  <= '0;
      word_d2  <= '0;
      word_d3  <= '0;
    end else begin
      if (rd_fire) begin
        word_cnt <= word_cnt + 1'b1;
      end
      word_d1 <= word_cnt;
      word_d2 <= word_d1;
      word_d3 <= word_d2;
    end
  end

  // write enable timing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fire_d1 <= 1'b0;
      eng_we  <= 1'b0;
    end else begin
      fire_d1 <= rd_fire;
      eng_we  <= fire_d1 && run;
    end
  end

  // ----------------------------------------------------------------------
  // per-lane accumulate, wraps modulo 2^N_LEN_W
  for (genvar l = 0; l < DATA_N; l++) begin : g_lane
    logic [N_LEN_W-1:0] lane_sum;

    always_ff @(posedge clk) begin
      if (fire_d1) begin
        lane_sum <= tab_rdata[l*N_LEN_W +: N_LEN_W]
                  + N_LEN_W'(grad[word_d1[SEL_W-1:0]][l*N_LEN +: N_LEN]);
      end
    end

    assign eng_wdata[l*N_LEN_W +: N_LEN_W] = lane_sum;
  end

endmodule

// ==== design/emb_wb_port.sv ====
`timescale 1ns/10ps

module emb_wb_port import emb_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  // wishbone slave
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [ADDR_WIDTH-1:0] wb_adr,
  input  logic [WORD_WIDTH-1:0] wb_wdata,
  output logic [WORD_WIDTH-1:0] wb_rdata,
  output logic                  wb_ack,
  // engine side
  input  logic [ADDR_WIDTH-1:0] eng_raddr,
  input  logic [ADDR_WIDTH-1:0] eng_waddr,
  input  logic [WORD_WIDTH-1:0] eng_wdata,
  input  logic                  eng_we,
  // table side
  input  logic [WORD_WIDTH-1:0] tab_rdata,
  output logic [ADDR_WIDTH-1:0] tab_raddr,
  output logic [ADDR_WIDTH-1:0] tab_waddr,
  output logic [WORD_WIDTH-1:0] tab_wdata,
  output logic                  tab_we
);

  // ----------------------------------------------------------------------
  logic ack_q;
  logic wb_req;

  // live request, masked in the ack cycle so stb still high is not taken twice
  assign wb_req = wb_cyc && wb_stb && !ack_q;

  // table owner: engine while run, bus otherwise
  always_comb begin
    if (run) begin
      tab_raddr = eng_raddr;
      tab_waddr = eng_waddr;
      tab_wdata = eng_wdata;
      tab_we    = eng_we;
    end else begin
      tab_raddr = wb_adr;
      tab_waddr = wb_adr;
      tab_wdata = wb_wdata;
      tab_we    = wb_req && wb_we;
    end
  end

  // ----------------------------------------------------------------------
  // ack pulse, held off while the engine owns the table
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_req && !run;
    end
  end

  assign wb_ack = ack_q;

  // read data lines up with ack
  assign wb_rdata = tab_rdata;

endmodule

// ==== design/emb_grad_top.sv ====
`timescale 1ns/10ps

module emb_grad_top import emb_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       run,
  input  logic [N*CHAR_LEN-1:0]      d_forward,
  input  logic [N*EMB_DIM*N_LEN-1:0] d_backward,
  output logic                       valid,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [ADDR_WIDTH-1:0]      wb_adr,
  input  logic [WORD_WIDTH-1:0]      wb_wdata,
  output logic [WORD_WIDTH-1:0]      wb_rdata,
  output logic                       wb_ack
);

  // ----------------------------------------------------------------------
  // engine to port
  logic [ADDR_WIDTH-1:0] eng_raddr;
  logic [ADDR_WIDTH-1:0] eng_waddr;
  logic [WORD_WIDTH-1:0] eng_wdata;
  logic                  eng_we;

  // port to table
  logic [ADDR_WIDTH-1:0] tab_raddr;
  logic [ADDR_WIDTH-1:0] tab_waddr;
  logic [WORD_WIDTH-1:0] tab_wdata;
  logic                  tab_we;
  logic [WORD_WIDTH-1:0] tab_rdata;

  emb_backward u_backward (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .d_forward  (d_forward),
    .d_backward (d_backward),
    .tab_rdata  (tab_rdata),
    .valid      (valid),
    .eng_raddr  (eng_raddr),
    .eng_waddr  (eng_waddr),
    .eng_wdata  (eng_wdata),
    .eng_we     (eng_we)
  );

  emb_wb_port u_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_wdata  (wb_wdata),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack),
    .eng_raddr (eng_raddr),
    .eng_waddr (eng_waddr),
    .eng_wdata (eng_wdata),
    .eng_we    (eng_we),
    .tab_rdata (tab_rdata),
    .tab_raddr (tab_raddr),
    .tab_waddr (tab_waddr),
    .tab_wdata (tab_wdata),
    .tab_we    (tab_we)
  );

  emb_table u_table (
    .clk   (clk),
    .raddr (tab_raddr),
    .rdata (tab_rdata),
    .waddr (tab_waddr),
    .wdata (tab_wdata),
    .we    (tab_we)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held over two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== sim/tb_emb_grad.sv ====
`timescale 1ns/10ps

module tb_emb_grad import emb_pkg::*; ();

  logic                       clk;
  logic                       rst_n;
  logic                       run;
  logic [N*CHAR_LEN-1:0]      d_forward;
  logic [N*EMB_DIM*N_LEN-1:0] d_backward;
  logic                       valid;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [ADDR_WIDTH-1:0]      wb_adr;
  logic [WORD_WIDTH-1:0]      wb_wdata;
  logic [WORD_WIDTH-1:0]      wb_rdata;
  logic                       wb_ack;

  // shadow table and pending readbacks
  logic [WORD_WIDTH-1:0] shadow [TABLE_DEPTH];
  logic [ADDR_WIDTH-1:0] chk_adr [$];
  logic [WORD_WIDTH-1:0] chk_data [$];
  logic [CHAR_LEN-1:0]   tok [N];
  logic [GRAD_WIDTH-1:0] grad [BATCH_WORDS];
  int errors;
  int start_errs;
  int tests_run;
  int tests_failed;

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  emb_grad_top u_dut (
    .clk(clk), .rst_n(rst_n), .run(run), .d_forward(d_forward),
    .d_backward(d_backward), .valid(valid), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata),
    .wb_ack(wb_ack)
  );

  // ----------------------------------------------------------------------
  // expected row word is the lane-wise sum of old weight and gradient mod 2^16
  function automatic logic [WORD_WIDTH-1:0] ref_word(input logic [WORD_WIDTH-1:0] old,
                                                     input logic [GRAD_WIDTH-1:0] g);
    logic [WORD_WIDTH-1:0] res;
    for (int l = 0; l < DATA_N; l++) begin
      res[l*N_LEN_W +: N_LEN_W] = old[l*N_LEN_W +: N_LEN_W] + g[l*N_LEN +: N_LEN];
    end
    return res;
  endfunction

  // readbacks compared at the falling edge
  always @(negedge clk) begin : compare
    logic [ADDR_WIDTH-1:0] a;
    logic [WORD_WIDTH-1:0] d;
    while (chk_adr.size() > 0) begin
      a = chk_adr.pop_front();
      d = chk_data.pop_front();
      assert (d === shadow[a]) else begin
        $display("ERR %0t: adr %0d expected %h got %h", $time, a, shadow[a], d);
        errors++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // one classic cycle and one idle cycle, entered 1 ns after a rising edge
  task automatic bus_xfer(input logic we, input logic [ADDR_WIDTH-1:0] adr,
                          input logic [WORD_WIDTH-1:0] wdata);
    int cycles;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    cycles   = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!wb_ack);
    assert (cycles == 1) else begin
      $display("ERR %0t: ack on adr %0d after %0d cycles", $time, adr, cycles);
      errors++;
    end
    if (we) begin
      shadow[adr] = wdata;
    end else begin
      chk_adr.push_back(adr);
      chk_data.push_back(wb_rdata);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic load_table();
    for (int a = 0; a < TABLE_DEPTH; a++) begin
      bus_xfer(1'b1, ADDR_WIDTH'(a), {$urandom, $urandom});
    end
  endtask

  task automatic read_table();
    for (int a = 0; a < TABLE_DEPTH; a++) begin
      bus_xfer(1'b0, ADDR_WIDTH'(a), '0);
    end
  endtask

  // tokens stay distinct within a batch while slot 0 may carry over
  task automatic pick_tokens(input bit keep_first);
    bit dup;
    for (int k = 0; k < N; k++) begin
      if (k == 0 && keep_first) begin
        continue;
      end
      do begin
        tok[k] = CHAR_LEN'($urandom);
        dup    = 1'b0;
        for (int i = 0; i < k; i++) begin
          if (tok[i] == tok[k]) begin
            dup = 1'b1;
          end
        end
      end while (dup);
    end
  endtask

  task automatic pick_grads(input bit near_max);
    for (int j = 0; j < BATCH_WORDS; j++) begin
      for (int l = 0; l < DATA_N; l++) begin
        if (near_max) begin
          grad[j][l*N_LEN +: N_LEN] = 16'hFFF0 | N_LEN'($urandom_range(15, 0));
        end else begin
          grad[j][l*N_LEN +: N_LEN] = N_LEN'($urandom);
        end
      end
    end
  endtask

  // drive the batch and time valid against edge 0 before folding it into the shadow
  task automatic apply_batch();
    int cycles;
    logic [ADDR_WIDTH-1:0] a;
    for (int k = 0; k < N; k++) begin
      d_forward[k*CHAR_LEN +: CHAR_LEN] = tok[k];
    end
    for (int j = 0; j < BATCH_WORDS; j++) begin
      d_backward[j*GRAD_WIDTH +: GRAD_WIDTH] = grad[j];
    end
    run = 1'b1;
    @(posedge clk);
    #1;
    cycles = 0;
    while (!valid && cycles < 4 * BATCH_WAIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (cycles == BATCH_WAIT) else begin
      $display("ERR %0t: valid after %0d cycles, expected %0d", $time, cycles, BATCH_WAIT);
      errors++;
    end
    for (int j = 0; j < BATCH_WORDS; j++) begin
      a = ADDR_WIDTH'(int'(tok[j / ROW_WORDS]) * ROW_WORDS + j % ROW_WORDS);
      shadow[a] = ref_word(shadow[a], grad[j]);
    end
    run = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == start_errs) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - start_errs);
    end
    start_errs = errors;
  endtask

  // ----------------------------------------------------------------------
  // watchdog at twice the summed test lengths in cycles
  initial begin : watchdog
    int limit;
    // reset plus five table passes, four batches and the stalled read
    limit = 2 * (2 + 5 * TABLE_DEPTH * 2 + 4 * (BATCH_WAIT + 2) + BATCH_WAIT + 4);
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [ADDR_WIDTH-1:0] stall_adr;
    void'($urandom(32'h1f5b1379));
    run        = 1'b0;
    d_forward  = '0;
    d_backward = '0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_wdata   = '0;
    errors     = 0;
    start_errs = 0;
    @(posedge rst_n);

    assert (valid === 1'b0 && wb_ack === 1'b0) else begin
      $display("ERR %0t: valid %b ack %b after reset", $time, valid, wb_ack);
      errors++;
    end
    end_test("reset state");

    load_table();
    read_table();
    end_test("table write and readback");

    load_table();
    pick_tokens(1'b0);
    pick_grads(1'b0);
    apply_batch();
    read_table();
    end_test("single batch");

    // zero gradient so the engine rewrites the same weights
    d_backward = '0;
    stall_adr  = ADDR_WIDTH'($urandom);
    run        = 1'b1;
    wb_cyc     = 1'b1;
    wb_stb     = 1'b1;
    wb_we      = 1'b0;
    wb_adr     = stall_adr;
    for (int c = 0; c < BATCH_WAIT + 2; c++) begin
      @(posedge clk);
      #1;
      assert (wb_ack === 1'b0) else begin
        $display("ERR %0t: ack while run is high", $time);
        errors++;
      end
    end
    run = 1'b0;
    @(posedge clk);
    #1;
    assert (wb_ack === 1'b1) else begin
      $display("ERR %0t: no ack on adr %0d one cycle after run fell", $time, stall_adr);
      errors++;
    end
    chk_adr.push_back(stall_adr);
    chk_data.push_back(wb_rdata);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(posedge clk);
    #1;
    end_test("read stalled by run");

    for (int b = 0; b < 3; b++) begin
      pick_tokens(b > 0);
      pick_grads(1'b1);
      apply_batch();
    end
    read_table();
    end_test("three batches with wraparound");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== emb_grad.f ====
design/emb_pkg.sv
design/emb_table.sv
design/emb_backward.sv
design/emb_wb_port.sv
design/emb_grad_top.sv
sim/tb_clock_gen.sv
sim/tb_emb_grad.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_emb_grad -f emb_grad.f -o tb_emb_grad
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_emb_grad > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error status, see sim.log"
  exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run passed"
  exit 0
else
  echo "run failed, see sim.log"
  exit 1
fi
